// ==== logic/sd_spi_pkg.sv ====
package sd_spi_pkg;

  // serial clock half periods from a 100 MHz clk
  // 400 kHz during identification
  localparam int sd_slow_div = 125;
  // 25 MHz once the card is ready
  localparam int sd_fast_div = 2;

  // about 1 ms with chip select high before CMD0
  localparam int sd_power_up_cycles = 100000;

  // serial bits without a start bit before a response is given up
  localparam int sd_resp_timeout = 100;
  // tries for the CMD0 loop and for the ACMD41 loop
  localparam int sd_retry_limit = 10;
  // bytes to wait for the data start token
  localparam int sd_token_limit = 256;

  localparam int sd_block_bytes = 512;
  localparam logic [7:0] sd_data_token = 8'hfe;

  // x^7 + x^3 + 1 without the top term
  localparam logic [6:0] sd_crc7_poly = 7'h09;

  // command indexes
  localparam logic [5:0] sd_cmd0 = 6'd0;
  localparam logic [5:0] sd_cmd8 = 6'd8;
  localparam logic [5:0] sd_cmd16 = 6'd16;
  localparam logic [5:0] sd_cmd17 = 6'd17;
  localparam logic [5:0] sd_cmd55 = 6'd55;
  localparam logic [5:0] sd_acmd41 = 6'd41;
  localparam logic [5:0] sd_cmd58 = 6'd58;

  // 2.7-3.6 V plus check pattern aa
  localparam logic [31:0] sd_arg_if_cond = 32'h0000_01aa;
  // host supports high capacity
  localparam logic [31:0] sd_arg_hcs = 32'h4000_0000;
  // ccs sits at ocr bit 30, the low 32 bits of r3
  localparam int sd_ocr_ccs_bit = 30;

  localparam logic [7:0] sd_r1_idle = 8'h01;
  localparam logic [7:0] sd_r1_ready = 8'h00;
  localparam logic [7:0] sd_r1_illegal = 8'h05;

  // r1 only, or r1 followed by 32 bits (r3 and r7)
  typedef enum logic {
    sd_resp_r1,
    sd_resp_long
  } sd_resp_kind_t;

  typedef struct packed {
    logic [5:0]    index;
    logic [31:0]   arg;
    sd_resp_kind_t kind;
    // a data block follows an r1 of 00
    logic          data_block;
  } sd_req_t;

endpackage

// ==== logic/sd_clock_gen.sv ====
`timescale 1ns/1ps

module sd_clock_gen #(
  parameter int slow_div = 125,
  parameter int fast_div = 2
) (
  input  logic clk,
  input  logic rst,
  input  logic fast_mode,
  output logic sd_cclk,
  output logic shift_tick,
  output logic sample_tick
);

  // sized for the slow rate, the larger count
  typedef logic [$clog2(slow_div + 1)-1:0] half_cnt_t;

  half_cnt_t half_cnt;
  half_cnt_t half_end;
  logic      half_wrap;

  // rate read every half period, so a switch lands on the next one
  assign half_end = fast_mode ? half_cnt_t'(fast_div - 1) : half_cnt_t'(slow_div - 1);
  // >= covers a switch to fast while the count is past the fast end
  assign half_wrap = (half_cnt >= half_end);

  // sd_cclk about to fall, data goes out
  assign shift_tick = half_wrap & sd_cclk;
  // sd_cclk about to rise, card data is stable
  assign sample_tick = half_wrap & ~sd_cclk;

  always_ff @(posedge clk) begin
    if (rst) begin
      half_cnt <= '0;
      sd_cclk <= 1'b0;
    end else if (half_wrap) begin
      half_cnt <= '0;
      sd_cclk <= ~sd_cclk;
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

endmodule

// ==== logic/sd_cmd_tx.sv ====
`timescale 1ns/1ps

module sd_cmd_tx (
  input  logic                clk,
  input  logic                rst,
  input  logic                shift_tick,
  input  logic                req_valid,
  input  sd_spi_pkg::sd_req_t req,
  output logic                sd_cmd,
  output logic                frame_done
);

  // start bits, index and argument, msb first
  logic [39:0] frame_sr;
  logic [6:0]  crc;
  logic [5:0]  bit_cnt;
  logic        busy;
  logic        crc_fb;

  // feedback of the serial crc7
  assign crc_fb = frame_sr[39] ^ crc[6];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      bit_cnt <= '0;
      sd_cmd <= 1'b1;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      if (req_valid) begin
        // 01 then index then argument
        frame_sr <= {2'b01, req.index, req.arg};
        crc <= '0;
        bit_cnt <= '0;
        busy <= 1'b1;
      end else if (busy && shift_tick) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt < 6'd40) begin
          // first 40 bits feed the crc as they leave
          sd_cmd <= frame_sr[39];
          frame_sr <= {frame_sr[38:0], 1'b0};
          crc <= {crc[5:0], 1'b0} ^ (crc_fb ? sd_spi_pkg::sd_crc7_poly : 7'h00);
        end else if (bit_cnt < 6'd47) begin
          // then the crc itself, msb first
          sd_cmd <= crc[6];
          crc <= {crc[5:0], 1'b0};
        end else begin
          // stop bit, line then idles high
          sd_cmd <= 1'b1;
          busy <= 1'b0;
          frame_done <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== logic/sd_resp_rx.sv ====
`timescale 1ns/1ps

module sd_resp_rx (
  input  logic                clk,
  input  logic                rst,
  input  logic                sample_tick,
  input  logic                frame_done,
  input  sd_spi_pkg::sd_req_t req,
  input  logic                sd_data0,
  output logic [39:0]         resp,
  output logic                resp_done,
  output logic                timeout,
  output logic [7:0]          block_byte,
  output logic                block_valid
);

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_resp,
    rx_token,
    rx_data,
    rx_crc
  } rx_state_t;

  rx_state_t   state;
  logic [39:0] rx_sr;
  logic [39:0] rx_next;
  logic [5:0]  bit_cnt;
  logic [5:0]  resp_last;
  // bit timeout, token bytes, data bytes and crc bits in turn
  logic [15:0] gen_cnt;

  assign rx_next = {rx_sr[38:0], sd_data0};
  assign resp_last = (req.kind == sd_spi_pkg::sd_resp_r1) ? 6'd7 : 6'd39;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rx_idle;
      resp_done <= 1'b0;
      timeout <= 1'b0;
      block_valid <= 1'b0;
    end else begin
      resp_done <= 1'b0;
      timeout <= 1'b0;
      block_valid <= 1'b0;
      if (state == rx_idle) begin
        if (frame_done) begin
          state <= rx_start;
          gen_cnt <= '0;
        end
      end else if (sample_tick) begin
        rx_sr <= rx_next;
        case (state)
          rx_start: begin
            // first 0 on data0 opens the response
            if (!sd_data0) begin
              bit_cnt <= 6'd1;
              state <= rx_resp;
            end else if (gen_cnt == 16'(sd_spi_pkg::sd_resp_timeout - 1)) begin
              timeout <= 1'b1;
              state <= rx_idle;
            end else begin
              gen_cnt <= gen_cnt + 1'b1;
            end
          end
          rx_resp: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == resp_last) begin
              // r1 always lands in the top byte
              resp <= (req.kind == sd_spi_pkg::sd_resp_r1) ? {rx_next[7:0], 32'd0} : rx_next;
              bit_cnt <= '0;
              gen_cnt <= '0;
              if (req.data_block && rx_next[7:0] == sd_spi_pkg::sd_r1_ready) begin
                state <= rx_token;
              end else begin
                resp_done <= 1'b1;
                state <= rx_idle;
              end
            end
          end
          rx_token: begin
            // bytes stay aligned to the end of r1
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 6'd7) begin
              bit_cnt <= '0;
              if (rx_next[7:0] == sd_spi_pkg::sd_data_token) begin
                gen_cnt <= '0;
                state <= rx_data;
              end else if (gen_cnt == 16'(sd_spi_pkg::sd_token_limit - 1)) begin
                timeout <= 1'b1;
                state <= rx_idle;
              end else begin
                gen_cnt <= gen_cnt + 1'b1;
              end
            end
          end
          rx_data: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 6'd7) begin
              bit_cnt <= '0;
              block_byte <= rx_next[7:0];
              block_valid <= 1'b1;
              gen_cnt <= gen_cnt + 1'b1;
              if (gen_cnt == 16'(sd_spi_pkg::sd_block_bytes - 1)) begin
                gen_cnt <= '0;
                state <= rx_crc;
              end
            end
          end
          rx_crc: begin
            // 16 bit data crc is dropped
            gen_cnt <= gen_cnt + 1'b1;
            if (gen_cnt == 16'd15) begin
              resp_done <= 1'b1;
              state <= rx_idle;
            end
          end
          default: state <= rx_idle;
        endcase
      end
    end
  end

endmodule

// ==== logic/sd_init_seq.sv ====
`timescale 1ns/1ps

module sd_init_seq #(
  parameter int power_up_cycles = 100000
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [39:0]         resp,
  input  logic                resp_done,
  input  logic                timeout,
  output logic                req_valid,
  output sd_spi_pkg::sd_req_t req,
  output logic                sd_cs,
  output logic                fast_mode,
  output logic                init_done,
  output logic                init_error,
  output logic                card_hc
);

  typedef enum logic [3:0] {
    st_power,
    st_cmd0,
    st_cmd8,
    st_cmd58,
    st_cmd55,
    st_acmd41,
    st_cmd16,
    st_cmd17,
    st_done,
    st_error
  } seq_state_t;

  typedef logic [$clog2(power_up_cycles + 1)-1:0] wait_cnt_t;

  seq_state_t state;
  wait_cnt_t  wait_cnt;
  logic [3:0] retry_cnt;
  // a command is out and its reply is awaited
  logic       pending;
  logic [7:0] r1;

  assign r1 = resp[39:32];
  assign init_done = (state == st_done);
  assign init_error = (state == st_error);

  function automatic sd_spi_pkg::sd_req_t make_req(
    input logic [5:0]                index,
    input logic [31:0]               arg,
    input sd_spi_pkg::sd_resp_kind_t kind,
    input logic                      data_block
  );
    sd_spi_pkg::sd_req_t r;
    r.index = index;
    r.arg = arg;
    r.kind = kind;
    r.data_block = data_block;
    return r;
  endfunction

  // request follows the state, so it stays put while pending
  always_comb begin
    case (state)
      st_cmd8: req = make_req(sd_spi_pkg::sd_cmd8, sd_spi_pkg::sd_arg_if_cond,
                              sd_spi_pkg::sd_resp_long, 1'b0);
      st_cmd58: req = make_req(sd_spi_pkg::sd_cmd58, 32'd0, sd_spi_pkg::sd_resp_long, 1'b0);
      st_cmd55: req = make_req(sd_spi_pkg::sd_cmd55, 32'd0, sd_spi_pkg::sd_resp_r1, 1'b0);
      st_acmd41: req = make_req(sd_spi_pkg::sd_acmd41, sd_spi_pkg::sd_arg_hcs,
                                sd_spi_pkg::sd_resp_r1, 1'b0);
      st_cmd16: req = make_req(sd_spi_pkg::sd_cmd16, 32'(sd_spi_pkg::sd_block_bytes),
                               sd_spi_pkg::sd_resp_r1, 1'b0);
      // byte address 0, block flagged
      st_cmd17: req = make_req(sd_spi_pkg::sd_cmd17, 32'd0, sd_spi_pkg::sd_resp_r1, 1'b1);
      default: req = make_req(sd_spi_pkg::sd_cmd0, 32'd0, sd_spi_pkg::sd_resp_r1, 1'b0);
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_power;
      wait_cnt <= '0;
      retry_cnt <= '0;
      pending <= 1'b0;
      req_valid <= 1'b0;
      sd_cs <= 1'b1;
      fast_mode <= 1'b0;
      card_hc <= 1'b0;
    end else begin
      req_valid <= 1'b0;
      if (state == st_power) begin
        // card powers up with cs high, then cs stays low
        if (wait_cnt == wait_cnt_t'(power_up_cycles - 1)) begin
          sd_cs <= 1'b0;
          state <= st_cmd0;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
      end else if (state != st_done && state != st_error) begin
        if (!pending) begin
          req_valid <= 1'b1;
          pending <= 1'b1;
        end else if (resp_done || timeout) begin
          pending <= 1'b0;
          case (state)
            st_cmd0: begin
              // reissue until idle or out of tries
              if (!timeout && r1 == sd_spi_pkg::sd_r1_idle) begin
                retry_cnt <= '0;
                state <= st_cmd8;
              end else if (retry_cnt == 4'(sd_spi_pkg::sd_retry_limit - 1)) begin
                state <= st_error;
              end else begin
                retry_cnt <= retry_cnt + 1'b1;
              end
            end
            st_cmd8: begin
              // legacy card rejects cmd8, newer one echoes voltage and pattern
              if (!timeout && (r1 == sd_spi_pkg::sd_r1_illegal ||
                  (r1 == sd_spi_pkg::sd_r1_idle &&
                   resp[15:0] == sd_spi_pkg::sd_arg_if_cond[15:0]))) begin
                state <= st_cmd58;
              end else begin
                state <= st_error;
              end
            end
            st_cmd58: begin
              card_hc <= resp[sd_spi_pkg::sd_ocr_ccs_bit];
              state <= timeout ? st_error : st_cmd55;
            end
            st_cmd55: state <= timeout ? st_error : st_acmd41;
            st_acmd41: begin
              if (timeout) begin
                state <= st_error;
              end else if (r1 == sd_spi_pkg::sd_r1_idle) begin
                // still initialising, run cmd55 again
                if (retry_cnt == 4'(sd_spi_pkg::sd_retry_limit - 1)) begin
                  state <= st_error;
                end else begin
                  retry_cnt <= retry_cnt + 1'b1;
                  state <= st_cmd55;
                end
              end else if (r1 == sd_spi_pkg::sd_r1_ready) begin
                // identification over, fast clock from here
                fast_mode <= 1'b1;
                state <= st_cmd16;
              end else begin
                state <= st_error;
              end
            end
            st_cmd16: begin
              state <= (!timeout && r1 == sd_spi_pkg::sd_r1_ready) ? st_cmd17 : st_error;
            end
            st_cmd17: begin
              // reply comes after the whole block
              state <= (!timeout && r1 == sd_spi_pkg::sd_r1_ready) ? st_done : st_error;
            end
            default: state <= st_error;
          endcase
        end
      end
    end
  end

endmodule

// ==== logic/sd_spi_host.sv ====
`timescale 1ns/1ps

module sd_spi_host #(
  parameter int slow_div = sd_spi_pkg::sd_slow_div,
  parameter int fast_div = sd_spi_pkg::sd_fast_div,
  parameter int power_up_cycles = sd_spi_pkg::sd_power_up_cycles
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       sd_data0,
  output logic       sd_cclk,
  output logic       sd_cmd,
  output logic       sd_cs,
  output logic       init_done,
  output logic       init_error,
  output logic       card_hc,
  output logic [7:0] block_byte,
  output logic       block_valid
);

  logic                fast_mode;
  logic                shift_tick;
  logic                sample_tick;
  // sequencer to transmitter and receiver
  logic                req_valid;
  sd_spi_pkg::sd_req_t req;
  // transmitter arms the receiver
  logic                frame_done;
  // receiver back to sequencer
  logic [39:0]         resp;
  logic                resp_done;
  logic                timeout;

  sd_clock_gen #(
    .slow_div(slow_div),
    .fast_div(fast_div)
  ) clock_gen0 (
    .clk        (clk),
    .rst        (rst),
    .fast_mode  (fast_mode),
    .sd_cclk    (sd_cclk),
    .shift_tick (shift_tick),
    .sample_tick(sample_tick)
  );

  sd_cmd_tx cmd_tx0 (
    .clk       (clk),
    .rst       (rst),
    .shift_tick(shift_tick),
    .req_valid (req_valid),
    .req       (req),
    .sd_cmd    (sd_cmd),
    .frame_done(frame_done)
  );

  sd_resp_rx resp_rx0 (
    .clk        (clk),
    .rst        (rst),
    .sample_tick(sample_tick),
    .frame_done (frame_done),
    .req        (req),
    .sd_data0   (sd_data0),
    .resp       (resp),
    .resp_done  (resp_done),
    .timeout    (timeout),
    .block_byte (block_byte),
    .block_valid(block_valid)
  );

  sd_init_seq #(
    .power_up_cycles(power_up_cycles)
  ) init_seq0 (
    .clk       (clk),
    .rst       (rst),
    .resp      (resp),
    .resp_done (resp_done),
    .timeout   (timeout),
    .req_valid (req_valid),
    .req       (req),
    .sd_cs     (sd_cs),
    .fast_mode (fast_mode),
    .init_done (init_done),
    .init_error(init_error),
    .card_hc   (card_hc)
  );

endmodule

// ==== verification/sd_host_checker.sv ====
`timescale 1ns/1ps

module sd_host_checker (
  input logic clk,
  input logic rst,
  input logic init_done,
  input logic init_error,
  input logic block_valid
);

  // the two outcomes exclude each other
  done_error_excl: assert property (@(posedge clk) disable iff (rst)
    !(init_done && init_error))
    else $error("init_done and init_error are high together");

  // outcome levels hold until the next reset
  done_holds: assert property (@(posedge clk) disable iff (rst)
    init_done |=> init_done)
    else $error("init_done fell without a reset");

  error_holds: assert property (@(posedge clk) disable iff (rst)
    init_error |=> init_error)
    else $error("init_error fell without a reset");

  // no data once bring-up has failed
  no_data_after_error: assert property (@(posedge clk) disable iff (rst)
    init_error |-> !block_valid)
    else $error("block_valid strobe after init_error");

endmodule

bind sd_spi_host sd_host_checker checker0 (
  .clk        (clk),
  .rst        (rst),
  .init_done  (init_done),
  .init_error (init_error),
  .block_valid(block_valid)
);

// ==== verification/sd_card_model.sv ====
`timescale 1ns/1ps

module sd_card_model (
  input  logic          clk,
  input  logic          rst,
  input  logic          sd_cclk,
  input  logic          sd_cs,
  input  logic          sd_cmd,
  input  logic [3:0]    idle_replies,
  input  logic          ccs,
  input  logic          legacy,
  input  logic          silent,
  input  logic [3:0]    gap_bytes,
  input  logic [4095:0] block_data,
  output logic          sd_data0
);

  // bits still to go out on data0, next one in front
  logic        out_q[$];
  logic [47:0] cmd_sr;
  logic        cclk_prev;
  int          cmd_bits;
  // acmd41 tries still answered with idle
  int          idle_left;

  initial sd_data0 = 1'b1;

  task automatic send_byte(input logic [7:0] b);
    int i;
    for (i = 7; i >= 0; i--) begin
      out_q.push_back(b[i]);
    end
  endtask

  task automatic send_word(input logic [31:0] w);
    int i;
    for (i = 3; i >= 0; i--) begin
      send_byte(w[8*i +: 8]);
    end
  endtask

  task automatic answer(input logic [5:0] index, input logic [31:0] arg);
    int k;
    // ncr, one byte of idle line first
    send_byte(8'hff);
    case (index)
      6'd0: send_byte(8'h01);
      6'd8: begin
        if (legacy) begin
          // old card does not know cmd8
          send_byte(8'h05);
        end else begin
          send_byte(8'h01);
          // voltage and check pattern echoed back
          send_word({20'd0, arg[11:0]});
        end
      end
      6'd58: begin
        send_byte(8'h01);
        // ocr with power up done, ccs at bit 30
        send_word({1'b1, ccs, 6'd0, 24'hff_8000});
      end
      6'd55: send_byte(8'h01);
      6'd41: begin
        if (idle_left > 0) begin
          idle_left--;
          send_byte(8'h01);
        end else begin
          send_byte(8'h00);
        end
      end
      6'd16: send_byte(8'h00);
      6'd17: begin
        send_byte(8'h00);
        repeat (gap_bytes) send_byte(8'hff);
        send_byte(8'hfe);
        for (k = 0; k < 512; k++) begin
          send_byte(block_data[8*k +: 8]);
        end
        // data crc, not checked by the host
        send_word(32'hffff_0000);
      end
      default: send_byte(8'h05);
    endcase
  endtask

  always @(posedge clk) begin
    cclk_prev <= sd_cclk;
    if (rst) begin
      cmd_bits = 0;
      idle_left = idle_replies;
      out_q.delete();
      sd_data0 <= 1'b1;
    end else begin
      // command bits taken after the serial clock rose
      if (sd_cclk && !cclk_prev && !sd_cs && (cmd_bits > 0 || !sd_cmd)) begin
        cmd_sr = {cmd_sr[46:0], sd_cmd};
        cmd_bits++;
        if (cmd_bits == 48) begin
          cmd_bits = 0;
          if (!silent) begin
            answer(cmd_sr[45:40], cmd_sr[39:8]);
          end
        end
      end
      // reply bits change after the serial clock fell
      if (!sd_cclk && cclk_prev) begin
        sd_data0 <= (out_q.size() > 0) ? out_q.pop_front() : 1'b1;
      end
    end
  end

endmodule

// ==== verification/sd_scoreboard.sv ====
`timescale 1ns/1ps

module sd_scoreboard #(
  parameter int power_up_cycles = sd_spi_pkg::sd_power_up_cycles
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        sd_cclk,
  input  logic        sd_cs,
  input  logic        sd_cmd,
  input  logic        init_done,
  input  logic        init_error,
  input  logic        card_hc,
  input  logic [7:0]  block_byte,
  input  logic        block_valid,
  input  logic [3:0]  cfg_idle,
  input  logic        cfg_hc,
  input  logic        cfg_silent,
  input  logic [31:0] block_seed,
  input  logic        test_start,
  input  logic        test_end,
  input  int          test_num,
  output int          err_count
);

  // index and argument of each frame still to come
  logic [37:0] exp_q[$];
  logic [47:0] frame_sr;
  logic        cclk_prev;
  logic        expect_done;
  logic [31:0] data_state;
  logic [39:0] ref_pair;
  int          frame_bits;
  int          frames;
  int          strobes;
  int          test_errs;
  // clk cycles with chip select high since reset
  int          cs_high_cycles;

  initial err_count = 0;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // next block byte from the stream, msb taken first
  function automatic logic [39:0] block_ref_step(input logic [31:0] s);
    logic [7:0] b;
    int         i;
    b = '0;
    for (i = 0; i < 8; i++) begin
      s = lfsr_next(s);
      b = {b[6:0], s[0]};
    end
    return {s, b};
  endfunction

  // crc7 over start bits, index and argument, x^7 + x^3 + 1
  function automatic logic [6:0] ref_crc7(input logic [39:0] bits);
    logic [6:0] c;
    logic       fb;
    int         i;
    c = '0;
    for (i = 39; i >= 0; i--) begin
      fb = bits[i] ^ c[6];
      c = {c[5:0], 1'b0};
      if (fb) begin
        c = c ^ 7'b000_1001;
      end
    end
    return c;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    test_errs++;
    err_count++;
  endtask

  task automatic build_expected();
    int pairs;
    exp_q.delete();
    if (cfg_silent) begin
      repeat (sd_spi_pkg::sd_retry_limit) exp_q.push_back({6'd0, 32'd0});
      expect_done = 1'b0;
    end else begin
      exp_q.push_back({6'd0, 32'd0});
      exp_q.push_back({6'd8, 32'h0000_01aa});
      exp_q.push_back({6'd58, 32'd0});
      // one pair per idle reply plus the one that ends idle
      expect_done = (cfg_idle < sd_spi_pkg::sd_retry_limit);
      pairs = expect_done ? cfg_idle + 1 : sd_spi_pkg::sd_retry_limit;
      repeat (pairs) begin
        exp_q.push_back({6'd55, 32'd0});
        exp_q.push_back({6'd41, 32'h4000_0000});
      end
      if (expect_done) begin
        exp_q.push_back({6'd16, 32'd512});
        exp_q.push_back({6'd17, 32'd0});
      end
    end
  endtask

  task automatic check_frame(input logic [47:0] f);
    logic [37:0] exp;
    frames++;
    if (f[46] !== 1'b1) begin
      report_error($sformatf("mismatch sd_cmd transmission bit: got %h expected 1", f[46]));
    end
    if (f[7:1] !== ref_crc7(f[47:8])) begin
      report_error($sformatf("mismatch sd_cmd crc7: got %h expected %h",
                             f[7:1], ref_crc7(f[47:8])));
    end
    if (f[0] !== 1'b1) begin
      report_error($sformatf("mismatch sd_cmd stop bit: got %h expected 1", f[0]));
    end
    if (exp_q.size() == 0) begin
      report_error($sformatf("command %0d sent after the expected sequence", f[45:40]));
    end else begin
      exp = exp_q.pop_front();
      if (f[45:8] !== exp) begin
        report_error($sformatf("mismatch sd_cmd index and arg: got %h expected %h",
                               f[45:8], exp));
      end
    end
  endtask

  task automatic finish_test();
    if (expect_done && !(init_done && !init_error)) begin
      report_error("init_done did not rise for a card that should come up");
    end
    if (!expect_done && !(init_error && !init_done)) begin
      report_error("init_error did not rise for a card that should fail");
    end
    if (expect_done && card_hc !== cfg_hc) begin
      report_error($sformatf("mismatch card_hc: got %h expected %h", card_hc, cfg_hc));
    end
    if (strobes != (expect_done ? 512 : 0)) begin
      report_error($sformatf("mismatch block_valid count: got %h expected %h",
                             strobes, expect_done ? 512 : 0));
    end
    // high for the power-up wait only, low from then on
    if (cs_high_cycles != power_up_cycles) begin
      report_error($sformatf("mismatch sd_cs high cycles: got %h expected %h",
                             cs_high_cycles, power_up_cycles));
    end
    if (exp_q.size() != 0) begin
      report_error($sformatf("%0d expected commands never went out", exp_q.size()));
    end
    if (test_errs == 0) begin
      $display("test %0d ok: %0d frames, %0d block bytes", test_num, frames, strobes);
    end else begin
      $display("test %0d bad: %0d errors", test_num, test_errs);
    end
  endtask

  always @(posedge clk) begin
    cclk_prev <= sd_cclk;
    if (test_start) begin
      build_expected();
      data_state = block_seed;
      frames = 0;
      strobes = 0;
      test_errs = 0;
    end
    if (rst) begin
      frame_bits = 0;
      cs_high_cycles = 0;
    end else begin
      if (sd_cs) begin
        cs_high_cycles++;
      end
      // frames decoded where the card takes them
      if (sd_cclk && !cclk_prev && !sd_cs && (frame_bits > 0 || !sd_cmd)) begin
        frame_sr = {frame_sr[46:0], sd_cmd};
        frame_bits++;
        if (frame_bits == 48) begin
          frame_bits = 0;
          check_frame(frame_sr);
        end
      end
    end
    if (block_valid) begin
      ref_pair = block_ref_step(data_state);
      data_state = ref_pair[39:8];
      strobes++;
      if (block_byte !== ref_pair[7:0]) begin
        report_error($sformatf("mismatch block_byte %0d: got %h expected %h",
                               strobes - 1, block_byte, ref_pair[7:0]));
      end
    end
    if (test_end) begin
      finish_test();
    end
  end

endmodule

// ==== verification/tb_sd_spi_host.sv ====
`timescale 1ns/1ps

module tb_sd_spi_host;

  localparam int clk_period = 40;
  localparam int slow_div = 4;
  localparam int fast_div = 1;
  localparam int power_up = 200;
  localparam int num_tests = 5;
  // every frame of the longest bring-up waits for a full response timeout
  localparam int frame_bits = 48 + sd_spi_pkg::sd_resp_timeout + 40;
  localparam int worst_bits = 2 * (sd_spi_pkg::sd_retry_limit + 3) * frame_bits
      + 8 * (sd_spi_pkg::sd_token_limit + sd_spi_pkg::sd_block_bytes + 4)
      + power_up / (2 * slow_div);
  localparam longint slow_bit_ns = 2 * slow_div * clk_period;
  localparam longint watchdog_ns = num_tests * worst_bits * slow_bit_ns + 100000;

  logic          clk = 1'b0;
  logic          rst = 1'b1;
  logic          sd_data0;
  logic          sd_cclk;
  logic          sd_cmd;
  logic          sd_cs;
  logic          init_done;
  logic          init_error;
  logic          card_hc;
  logic [7:0]    block_byte;
  logic          block_valid;
  // card setup for the running test
  logic [3:0]    cfg_idle = '0;
  logic          cfg_hc = 1'b0;
  logic          cfg_legacy = 1'b0;
  logic          cfg_silent = 1'b0;
  logic [3:0]    cfg_gap = '0;
  logic [4095:0] block_data = '0;
  logic [31:0]   block_seed = '0;
  logic          test_start = 1'b0;
  logic          test_end = 1'b0;
  int            test_num = 0;
  int            err_count;
  logic [31:0]   lfsr_state = 32'hf405_56f5;

  always #(clk_period / 2) clk = ~clk;

  sd_spi_host #(
    .slow_div       (slow_div),
    .fast_div       (fast_div),
    .power_up_cycles(power_up)
  ) dut0 (
    .clk        (clk),
    .rst        (rst),
    .sd_data0   (sd_data0),
    .sd_cclk    (sd_cclk),
    .sd_cmd     (sd_cmd),
    .sd_cs      (sd_cs),
    .init_done  (init_done),
    .init_error (init_error),
    .card_hc    (card_hc),
    .block_byte (block_byte),
    .block_valid(block_valid)
  );

  sd_card_model card0 (
    .clk         (clk),
    .rst         (rst),
    .sd_cclk     (sd_cclk),
    .sd_cs       (sd_cs),
    .sd_cmd      (sd_cmd),
    .idle_replies(cfg_idle),
    .ccs         (cfg_hc),
    .legacy      (cfg_legacy),
    .silent      (cfg_silent),
    .gap_bytes   (cfg_gap),
    .block_data  (block_data),
    .sd_data0    (sd_data0)
  );

  sd_scoreboard #(
    .power_up_cycles(power_up)
  ) scoreboard0 (
    .clk        (clk),
    .rst        (rst),
    .sd_cclk    (sd_cclk),
    .sd_cs      (sd_cs),
    .sd_cmd     (sd_cmd),
    .init_done  (init_done),
    .init_error (init_error),
    .card_hc    (card_hc),
    .block_byte (block_byte),
    .block_valid(block_valid),
    .cfg_idle   (cfg_idle),
    .cfg_hc     (cfg_hc),
    .cfg_silent (cfg_silent),
    .block_seed (block_seed),
    .test_start (test_start),
    .test_end   (test_end),
    .test_num   (test_num),
    .err_count  (err_count)
  );

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic run_test(input logic [3:0] idle, input logic hc, input logic legacy,
                          input logic silent, input logic [3:0] gap);
    logic [4095:0] data_v;
    logic [31:0]   seed_v;
    logic [31:0]   v;
    int            k;
    // block data continues the same random stream
    seed_v = lfsr_state;
    for (k = 0; k < 512; k++) begin
      take_bits(8, v);
      data_v[8*k +: 8] = v[7:0];
    end
    @(posedge clk);
    rst <= 1'b1;
    cfg_idle <= idle;
    cfg_hc <= hc;
    cfg_legacy <= legacy;
    cfg_silent <= silent;
    cfg_gap <= gap;
    block_seed <= seed_v;
    block_data <= data_v;
    @(posedge clk);
    test_start <= 1'b1;
    @(posedge clk);
    test_start <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // bring-up length depends on the card
    while (!init_done && !init_error) @(posedge clk);
    repeat (4) @(posedge clk);
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
    test_num <= test_num + 1;
    @(posedge clk);
  endtask

  initial begin
    logic [31:0] v;
    logic [3:0]  idle_v;
    logic        hc_v;
    logic [3:0]  gap_v;
    int          t;
    hc_v = 1'b0;
    // two normal cards, then a legacy one
    for (t = 0; t < 3; t++) begin
      take_bits(4, v);
      idle_v = 4'(v % 10);
      take_bits(1, v);
      // capacity alternates so card_hc is seen at both values
      hc_v = (t == 0) ? v[0] : ~hc_v;
      take_bits(4, v);
      gap_v = v[3:0];
      run_test(idle_v, hc_v, t == 2, 1'b0, gap_v);
    end
    // never leaves idle within the retry limit
    take_bits(1, v);
    run_test(4'd12, v[0], 1'b0, 1'b0, 4'd0);
    // no reply to cmd0 at all
    run_test(4'd0, 1'b0, 1'b0, 1'b1, 4'd0);
    repeat (2) @(posedge clk);
    $display("%0d tests run, %0d errors", num_tests, err_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the test list finished");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/sd_spi_pkg.sv
logic/sd_clock_gen.sv
logic/sd_cmd_tx.sv
logic/sd_resp_rx.sv
logic/sd_init_seq.sv
logic/sd_spi_host.sv
verification/sd_host_checker.sv
verification/sd_card_model.sv
verification/sd_scoreboard.sv
verification/tb_sd_spi_host.sv
